// ==== rtl/core_defines.svh ====
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// --------------------------------------------------
// Core-wide sizing
// --------------------------------------------------

// Data path and instruction word width
`define CORE_XLEN 32

// Register index width and number of architectural registers
`define CORE_REG_INDEX_W 5
`define CORE_REG_COUNT 32

// First program counter after reset
`define CORE_RESET_PC 32'h00000000

`endif

// ==== rtl/core_pkg.sv ====
`default_nettype none

package core_pkg;

    // --------------------------------------------------
    // Major opcodes of the supported RV32I subset
    // --------------------------------------------------
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_e;

    // ALU operations, PASS_B forwards operand b untouched
    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, PASS_B
    } alu_op_e;

    // --------------------------------------------------
    // Instruction word formats
    // --------------------------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_format_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_format_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_format_t;

    // Same 32-bit word, three views
    typedef union packed {
        r_format_t r;
        i_format_t i;
        u_format_t u;
    } instr_u;

endpackage

`default_nettype wire

// ==== rtl/pipe_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

// Decode to execute stage register
interface exec_if;
    import core_pkg::*;

    logic                         valid;
    logic                         illegal;
    alu_op_e                      alu_op;
    logic [`CORE_XLEN-1:0]        pc;
    logic [`CORE_XLEN-1:0]        operand_a;
    logic [`CORE_XLEN-1:0]        operand_b;
    logic [`CORE_REG_INDEX_W-1:0] rs1;
    logic [`CORE_REG_INDEX_W-1:0] rs2;
    // Operand came from a register, forwarding may override it
    logic                         fwd_a;
    logic                         fwd_b;
    logic [`CORE_REG_INDEX_W-1:0] rd;
    logic                         writes;

    modport source (output valid, illegal, alu_op, pc, operand_a, operand_b,
                    rs1, rs2, fwd_a, fwd_b, rd, writes);
    modport sink   (input  valid, illegal, alu_op, pc, operand_a, operand_b,
                    rs1, rs2, fwd_a, fwd_b, rd, writes);
endinterface

// Execute result register, read by writeback
interface result_if;
    logic                         valid;
    logic                         illegal;
    logic [`CORE_XLEN-1:0]        pc;
    logic [`CORE_REG_INDEX_W-1:0] rd;
    logic                         writes;
    logic [`CORE_XLEN-1:0]        data;

    modport source (output valid, illegal, pc, rd, writes, data);
    modport sink   (input  valid, illegal, pc, rd, writes, data);
endinterface

`default_nettype wire

// ==== rtl/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module register_file (
    input  wire logic                         CLK,
    input  wire logic                         reset,
    input  wire logic [`CORE_REG_INDEX_W-1:0] read_index_1,
    input  wire logic [`CORE_REG_INDEX_W-1:0] read_index_2,
    output logic [`CORE_XLEN-1:0]             read_data_1,
    output logic [`CORE_XLEN-1:0]             read_data_2,
    input  wire logic                         write_enable,
    input  wire logic [`CORE_REG_INDEX_W-1:0] write_index,
    input  wire logic [`CORE_XLEN-1:0]        write_data
);

    // x1 to x31, x0 has no storage
    logic [`CORE_XLEN-1:0] regs [1:`CORE_REG_COUNT-1];

    // Read port with write-through of a same-cycle write
    function automatic logic [`CORE_XLEN-1:0] read_port(
        input logic [`CORE_REG_INDEX_W-1:0] index
    );
        if (index == '0)
            return '0;
        else if (write_enable && write_index == index)
            return write_data;
        else
            return regs[index];
    endfunction

    always_comb
    begin
        read_data_1 = read_port(read_index_1);
        read_data_2 = read_port(read_index_2);
    end

    // --------------------------------------------------
    // Write port, all registers clear on reset
    // --------------------------------------------------
    always_ff @(posedge CLK)
    begin
        for (int i = 1; i < `CORE_REG_COUNT; i++)
        begin
            if (reset)
                regs[i] <= '0;
            else if (write_enable && write_index == i)
                regs[i] <= write_data;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module fetch_stage (
    input  wire logic                  CLK,
    input  wire logic                  reset,
    input  wire logic                  instr_valid,
    input  wire logic [`CORE_XLEN-1:0] instr,
    output logic                       f_valid,
    output core_pkg::instr_u           f_instr,
    output logic [`CORE_XLEN-1:0]      f_pc
);
    import core_pkg::*;

    localparam logic [`CORE_XLEN-1:0] PC_STEP = 4;

    // Address given to the next accepted word
    logic [`CORE_XLEN-1:0] pc_next;

    // --------------------------------------------------
    // Valid strobe and program counter
    // --------------------------------------------------
    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            f_valid <= 1'b0;
            pc_next <= `CORE_RESET_PC;
        end
        else
        begin
            f_valid <= instr_valid;
            // Advance only for accepted words
            if (instr_valid)
                pc_next <= pc_next + PC_STEP;
        end
    end

    // Word and its pc, qualified by f_valid
    always_ff @(posedge CLK)
    begin
        f_instr <= instr_u'(instr);
        f_pc    <= pc_next;
    end

endmodule

`default_nettype wire

// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module decode_stage (
    input  wire logic                         CLK,
    input  wire logic                         reset,
    input  wire logic                         f_valid,
    input  wire core_pkg::instr_u             f_instr,
    input  wire logic [`CORE_XLEN-1:0]        f_pc,
    input  wire logic                         rf_we,
    input  wire logic [`CORE_REG_INDEX_W-1:0] rf_index,
    input  wire logic [`CORE_XLEN-1:0]        rf_data,
    exec_if.source                            ex
);
    import core_pkg::*;

    opcode_e               opcode;
    logic [`CORE_XLEN-1:0] imm_i;
    logic [`CORE_XLEN-1:0] imm_u;
    logic [`CORE_XLEN-1:0] read_data_1;
    logic [`CORE_XLEN-1:0] read_data_2;
    alu_op_e               alu_op_d;
    logic [`CORE_XLEN-1:0] operand_a_d;
    logic [`CORE_XLEN-1:0] operand_b_d;
    logic                  fwd_a_d;
    logic                  fwd_b_d;
    logic                  illegal_d;
    logic [2:0]            funct3;
    logic [6:0]            funct7;

    // --------------------------------------------------
    // Field extraction through the three views
    // --------------------------------------------------
    assign opcode = opcode_e'(f_instr.r.opcode);
    assign funct3 = f_instr.r.funct3;
    assign funct7 = f_instr.r.funct7;
    // I immediate is sign extended
    assign imm_i  = {{(`CORE_XLEN-12){f_instr.i.imm[11]}}, f_instr.i.imm};
    // U immediate fills the upper bits
    assign imm_u  = {f_instr.u.imm, 12'b0};

    register_file rf_inst (
        .CLK          (CLK),
        .reset        (reset),
        .read_index_1 (f_instr.r.rs1),
        .read_index_2 (f_instr.r.rs2),
        .read_data_1  (read_data_1),
        .read_data_2  (read_data_2),
        .write_enable (rf_we),
        .write_index  (rf_index),
        .write_data   (rf_data)
    );

    // --------------------------------------------------
    // Operation and operand selection
    // --------------------------------------------------
    always_comb
    begin
        alu_op_d    = ADD;
        operand_a_d = read_data_1;
        operand_b_d = read_data_2;
        fwd_a_d     = 1'b0;
        fwd_b_d     = 1'b0;
        illegal_d   = 1'b0;
        case (opcode)
            OP, OP_IMM:
            begin
                fwd_a_d = 1'b1;
                case (funct3)
                    3'b000:  alu_op_d = (opcode == OP && funct7[5]) ? SUB : ADD;
                    3'b001:  alu_op_d = SLL;
                    3'b010:  alu_op_d = SLT;
                    3'b011:  alu_op_d = SLTU;
                    3'b100:  alu_op_d = XOR;
                    // funct7 bit 5 sits at imm bit 10 for the I form too
                    3'b101:  alu_op_d = funct7[5] ? SRA : SRL;
                    3'b110:  alu_op_d = OR;
                    default: alu_op_d = AND;
                endcase
                if (opcode == OP)
                begin
                    fwd_b_d = 1'b1;
                    // Only base funct7 or the alternate form of ADD and SRL
                    if (funct7 != 7'b0000000 &&
                        !(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)))
                        illegal_d = 1'b1;
                end
                else
                    operand_b_d = imm_i;
            end
            LUI:
            begin
                alu_op_d    = PASS_B;
                operand_a_d = '0;
                operand_b_d = imm_u;
            end
            AUIPC:
            begin
                operand_a_d = f_pc;
                operand_b_d = imm_u;
            end
            default: illegal_d = 1'b1;
        endcase
    end

    // --------------------------------------------------
    // Decode to execute register
    // --------------------------------------------------
    always_ff @(posedge CLK)
    begin
        if (reset)
            ex.valid <= 1'b0;
        else
            ex.valid <= f_valid;
    end

    always_ff @(posedge CLK)
    begin
        ex.illegal   <= illegal_d;
        ex.alu_op    <= alu_op_d;
        ex.pc        <= f_pc;
        ex.operand_a <= operand_a_d;
        ex.operand_b <= operand_b_d;
        ex.rs1       <= f_instr.r.rs1;
        ex.rs2       <= f_instr.r.rs2;
        ex.fwd_a     <= fwd_a_d;
        ex.fwd_b     <= fwd_b_d;
        ex.rd        <= f_instr.u.rd;
        // Illegal words never write
        ex.writes    <= !illegal_d;
    end

endmodule

`default_nettype wire

// ==== rtl/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module execute_stage (
    input  wire logic CLK,
    input  wire logic reset,
    exec_if.sink      ex,
    result_if.source  res
);
    import core_pkg::*;

    logic                  hit_a;
    logic                  hit_b;
    logic [`CORE_XLEN-1:0] op_a;
    logic [`CORE_XLEN-1:0] op_b;
    logic [4:0]            shamt;
    logic [`CORE_XLEN-1:0] alu_result;

    // --------------------------------------------------
    // Forwarding from the held result
    // --------------------------------------------------
    // Producer one instruction older sits in the result register
    assign hit_a = ex.fwd_a && res.valid && res.writes &&
                   res.rd != '0 && res.rd == ex.rs1;
    assign hit_b = ex.fwd_b && res.valid && res.writes &&
                   res.rd != '0 && res.rd == ex.rs2;

    assign op_a  = hit_a ? res.data : ex.operand_a;
    assign op_b  = hit_b ? res.data : ex.operand_b;

    // Shifts use the low five bits only
    assign shamt = op_b[4:0];

    // --------------------------------------------------
    // ALU
    // --------------------------------------------------
    always_comb
    begin
        case (ex.alu_op)
            ADD:     alu_result = op_a + op_b;
            SUB:     alu_result = op_a - op_b;
            SLL:     alu_result = op_a << shamt;
            SLT:     alu_result = {{(`CORE_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            SLTU:    alu_result = {{(`CORE_XLEN-1){1'b0}}, op_a < op_b};
            XOR:     alu_result = op_a ^ op_b;
            SRL:     alu_result = op_a >> shamt;
            SRA:     alu_result = $unsigned($signed(op_a) >>> shamt);
            OR:      alu_result = op_a | op_b;
            AND:     alu_result = op_a & op_b;
            PASS_B:  alu_result = op_b;
            default: alu_result = '0;
        endcase
    end

    // --------------------------------------------------
    // Execute result register
    // --------------------------------------------------
    always_ff @(posedge CLK)
    begin
        if (reset)
            res.valid <= 1'b0;
        else
            res.valid <= ex.valid;
    end

    always_ff @(posedge CLK)
    begin
        res.illegal <= ex.illegal;
        res.pc      <= ex.pc;
        res.rd      <= ex.rd;
        res.writes  <= ex.writes;
        res.data    <= alu_result;
    end

endmodule

`default_nettype wire

// ==== rtl/writeback_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module writeback_stage (
    input  wire logic                    CLK,
    input  wire logic                    reset,
    result_if.sink                       res,
    output logic                         rf_we,
    output logic [`CORE_REG_INDEX_W-1:0] rf_index,
    output logic [`CORE_XLEN-1:0]        rf_data,
    output logic                         wb_valid,
    output logic                         wb_illegal,
    output logic [`CORE_XLEN-1:0]        wb_pc,
    output logic [`CORE_REG_INDEX_W-1:0] wb_index,
    output logic [`CORE_XLEN-1:0]        wb_data,
    output logic [`CORE_XLEN-1:0]        retired
);

    // --------------------------------------------------
    // Register file write port
    // --------------------------------------------------
    // x0 writes are dropped here and nowhere else
    assign rf_we    = res.valid && res.writes && res.rd != '0;
    assign rf_index = res.rd;
    assign rf_data  = res.data;

    // --------------------------------------------------
    // Retire outputs and counter
    // --------------------------------------------------
    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            wb_valid   <= 1'b0;
            wb_illegal <= 1'b0;
            retired    <= '0;
        end
        else
        begin
            wb_valid   <= res.valid;
            wb_illegal <= res.valid && res.illegal;
            // Illegal words retire but are not counted
            if (res.valid && !res.illegal)
                retired <= retired + 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        wb_pc    <= res.pc;
        wb_index <= res.rd;
        wb_data  <= res.data;
    end

endmodule

`default_nettype wire

// ==== rtl/rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module rv_core (
    input  wire logic                         CLK,
    input  wire logic                         reset,
    input  wire logic                         instr_valid,
    input  wire logic [`CORE_XLEN-1:0]        instr,
    output logic                              wb_valid,
    output logic                              wb_illegal,
    output logic [`CORE_XLEN-1:0]             wb_pc,
    output logic [`CORE_XLEN-1:0]             wb_data,
    output logic [`CORE_REG_INDEX_W-1:0]      wb_index,
    output logic [`CORE_XLEN-1:0]             retired
);
    import core_pkg::*;

    // --------------------------------------------------
    // Stage links
    // --------------------------------------------------
    logic                         f_valid;
    instr_u                       f_instr;
    logic [`CORE_XLEN-1:0]        f_pc;

    // Register file write, from writeback back into decode
    logic                         rf_we;
    logic [`CORE_REG_INDEX_W-1:0] rf_index;
    logic [`CORE_XLEN-1:0]        rf_data;

    exec_if   exec_bus ();
    result_if result_bus ();

    // --------------------------------------------------
    // Pipeline stages
    // --------------------------------------------------
    fetch_stage fetch_inst (
        .CLK         (CLK),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .f_valid     (f_valid),
        .f_instr     (f_instr),
        .f_pc        (f_pc)
    );

    decode_stage decode_inst (
        .CLK      (CLK),
        .reset    (reset),
        .f_valid  (f_valid),
        .f_instr  (f_instr),
        .f_pc     (f_pc),
        .rf_we    (rf_we),
        .rf_index (rf_index),
        .rf_data  (rf_data),
        .ex       (exec_bus.source)
    );

    execute_stage execute_inst (
        .CLK   (CLK),
        .reset (reset),
        .ex    (exec_bus.sink),
        .res   (result_bus.source)
    );

    writeback_stage writeback_inst (
        .CLK        (CLK),
        .reset      (reset),
        .res        (result_bus.sink),
        .rf_we      (rf_we),
        .rf_index   (rf_index),
        .rf_data    (rf_data),
        .wb_valid   (wb_valid),
        .wb_illegal (wb_illegal),
        .wb_pc      (wb_pc),
        .wb_index   (wb_index),
        .wb_data    (wb_data),
        .retired    (retired)
    );

endmodule

`default_nettype wire

// ==== test/rv_core_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module rv_core_sva (
    input wire logic                  CLK,
    input wire logic                  reset,
    input wire logic                  wb_valid,
    input wire logic                  wb_illegal,
    input wire logic                  rf_we,
    input wire logic [`CORE_XLEN-1:0] retired
);

    // --------------------------------------------------
    // Retire outputs around reset
    // --------------------------------------------------
    // Retire strobe comes out of reset low
    reset_clears_retire: assert property (@(posedge CLK) reset |=> !wb_valid)
        else $error("wb_valid high in the cycle after reset");

    // Counter only moves up once running
    retired_never_drops: assert property (@(posedge CLK) disable iff (reset)
        retired >= $past(retired))
        else $error("retired count decreased");

    // --------------------------------------------------
    // Illegal words leave the register file alone
    // --------------------------------------------------
    // rf_we leads the retire register by one cycle for the same word
    illegal_never_writes: assert property (@(posedge CLK) disable iff (reset)
        rf_we |=> !wb_illegal)
        else $error("register file written by an illegal word");

endmodule

// Hooked onto the writeback stage inside the core
bind writeback_stage rv_core_sva sva_inst (
    .CLK        (CLK),
    .reset      (reset),
    .wb_valid   (wb_valid),
    .wb_illegal (wb_illegal),
    .rf_we      (rf_we),
    .retired    (retired)
);

`default_nettype wire

// ==== test/rv_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module rv_core_tb;
    import core_pkg::*;

    localparam int NUM_INSTR   = 400;
    localparam int DRAIN_LIMIT = 50;
    localparam int LATENCY     = 3;

    // Expected retire record, one per accepted word
    typedef struct packed {
        logic [`CORE_XLEN-1:0]        pc;
        logic [`CORE_REG_INDEX_W-1:0] index;
        logic [`CORE_XLEN-1:0]        data;
        logic                         illegal;
        logic [31:0]                  accept_edge;
    } expect_t;

    logic                         CLK;
    logic                         reset;
    logic                         instr_valid;
    logic [`CORE_XLEN-1:0]        instr;
    logic                         wb_valid;
    logic                         wb_illegal;
    logic [`CORE_XLEN-1:0]        wb_pc;
    logic [`CORE_XLEN-1:0]        wb_data;
    logic [`CORE_REG_INDEX_W-1:0] wb_index;
    logic [`CORE_XLEN-1:0]        retired;

    // Architectural model state
    expect_t               expect_q [$];
    logic [`CORE_XLEN-1:0] model_regs [0:`CORE_REG_COUNT-1];
    logic [`CORE_XLEN-1:0] model_pc;
    int                    legal_count;
    int                    legal_retired;
    int                    edge_count;
    int                    value_errors;
    int                    other_errors;

    rv_core rv_core_inst (
        .CLK         (CLK),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_illegal  (wb_illegal),
        .wb_pc       (wb_pc),
        .wb_data     (wb_data),
        .wb_index    (wb_index),
        .retired     (retired)
    );

    // 40 ns clock
    initial CLK = 1'b0;
    always #20 CLK = ~CLK;

    // Rising edges since time zero
    always @(posedge CLK)
        edge_count <= edge_count + 1;

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic check_word(input string name, input logic [`CORE_XLEN-1:0] exp,
                              input logic [`CORE_XLEN-1:0] act);
        if (act !== exp)
        begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_index(input string name, input logic [`CORE_REG_INDEX_W-1:0] exp,
                               input logic [`CORE_REG_INDEX_W-1:0] act);
        if (act !== exp)
        begin
            $display("[FAIL] %s expected x%0d actual x%0d", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("[FAIL] %s expected %b actual %b", name, exp, act);
            value_errors++;
        end
    endtask

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    // RV32I arithmetic by funct3, alt is funct7 bit 5
    function automatic logic [`CORE_XLEN-1:0] reference_alu(input logic [2:0] f3,
        input logic alt, input logic is_reg, input logic [`CORE_XLEN-1:0] a,
        input logic [`CORE_XLEN-1:0] b);
        case (f3)
            3'b000:  return (is_reg && alt) ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 1 : 0;
            3'b011:  return (a < b) ? 1 : 0;
            3'b100:  return a ^ b;
            3'b101:
            begin
                if (alt)
                    return $unsigned($signed(a) >>> b[4:0]);
                else
                    return a >> b[4:0];
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // Executes one accepted word and queues what must retire
    task automatic model_accept(input logic [`CORE_XLEN-1:0] word);
        instr_u                w;
        logic [`CORE_XLEN-1:0] imm_i;
        logic [`CORE_XLEN-1:0] imm_u;
        logic [`CORE_XLEN-1:0] result;
        logic                  illegal;
        expect_t               entry;
        w       = instr_u'(word);
        imm_i   = {{(`CORE_XLEN-12){w.i.imm[11]}}, w.i.imm};
        imm_u   = {w.u.imm, 12'b0};
        result  = '0;
        illegal = 1'b0;
        case (w.r.opcode)
            OP:
            begin
                illegal = w.r.funct7 != 7'b0000000 && !(w.r.funct7 == 7'b0100000 &&
                          (w.r.funct3 == 3'b000 || w.r.funct3 == 3'b101));
                result  = reference_alu(w.r.funct3, w.r.funct7[5], 1'b1,
                                        model_regs[w.r.rs1], model_regs[w.r.rs2]);
            end
            OP_IMM:
                result = reference_alu(w.i.funct3, w.i.imm[10], 1'b0,
                                       model_regs[w.i.rs1], imm_i);
            LUI:     result = imm_u;
            AUIPC:   result = model_pc + imm_u;
            default: illegal = 1'b1;
        endcase
        // x0 keeps zero, the computed value still retires
        if (!illegal && w.r.rd != 0)
            model_regs[w.r.rd] = result;
        entry.pc          = model_pc;
        entry.index       = w.r.rd;
        entry.data        = result;
        entry.illegal     = illegal;
        entry.accept_edge = edge_count + 1;
        expect_q.push_back(entry);
        model_pc = model_pc + 4;
        if (!illegal)
            legal_count++;
    endtask

    // --------------------------------------------------
    // Random instruction words
    // --------------------------------------------------
    // Registers x0 to x7 only, so hazards are frequent
    function automatic logic [`CORE_XLEN-1:0] make_word();
        int unsigned kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        kind = $urandom_range(0, 99);
        rd   = 5'($urandom_range(0, 7));
        rs1  = 5'($urandom_range(0, 7));
        rs2  = 5'($urandom_range(0, 7));
        f3   = 3'($urandom_range(0, 7));
        f7   = 7'b0000000;
        // Alternate form only where RV32I defines one
        if ((f3 == 3'b000 || f3 == 3'b101) && $urandom_range(0, 1) == 1)
            f7 = 7'b0100000;
        imm = 12'($urandom());
        if (f3 == 3'b001)
            imm[11:5] = 7'b0000000;
        else if (f3 == 3'b101)
            imm[11:5] = f7;
        if (kind < 4)
            return {7'($urandom()), rs2, rs1, f3, rd, 5'($urandom()), 2'b00};
        else if (kind < 8)
            return {7'($urandom()), rs2, rs1, f3, rd, OP};
        else if (kind < 45)
            return {f7, rs2, rs1, f3, rd, OP};
        else if (kind < 80)
            return {imm, rs1, f3, rd, OP_IMM};
        else if (kind < 90)
            return {20'($urandom()), rd, LUI};
        else
            return {20'($urandom()), rd, AUIPC};
    endfunction

    // --------------------------------------------------
    // Retire monitor and model feed, away from the driving edge
    // --------------------------------------------------
    always @(negedge CLK)
    begin
        expect_t head;
        if (reset && wb_valid !== 1'b0)
        begin
            $display("Retire strobe was not low while reset was asserted");
            other_errors++;
        end
        else if (wb_valid)
        begin
            if (expect_q.size() == 0)
            begin
                $display("A retire showed up at pc %h with nothing outstanding", wb_pc);
                other_errors++;
            end
            else
            begin
                head = expect_q.pop_front();
                if (!head.illegal)
                    legal_retired++;
                check_word("retire edge", head.accept_edge + LATENCY, edge_count);
                check_word("pc", head.pc, wb_pc);
                check_index("rd", head.index, wb_index);
                check_flag("illegal", head.illegal, wb_illegal);
                // Data of an illegal word has no meaning
                if (!head.illegal)
                    check_word("data", head.data, wb_data);
                check_word("retired", legal_retired, retired);
            end
        end
        // The next rising edge samples these inputs
        if (!reset && instr_valid)
            model_accept(instr);
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial
    begin
        int sent;
        int wait_cycles;
        void'($urandom(15293));
        reset         = 1'b1;
        instr_valid   = 1'b0;
        instr         = '0;
        edge_count    = 0;
        legal_count   = 0;
        legal_retired = 0;
        value_errors  = 0;
        other_errors  = 0;
        model_pc      = `CORE_RESET_PC;
        for (int i = 0; i < `CORE_REG_COUNT; i++)
            model_regs[i] = '0;
        repeat (8) @(posedge CLK);
        reset <= 1'b0;
        sent = 0;
        while (sent < NUM_INSTR)
        begin
            @(posedge CLK);
            // Roughly one idle cycle in five
            if ($urandom_range(0, 4) == 0)
                instr_valid <= 1'b0;
            else
            begin
                instr_valid <= 1'b1;
                instr       <= make_word();
                sent++;
            end
        end
        @(posedge CLK);
        instr_valid <= 1'b0;
        // Drain the pipeline
        wait_cycles = 0;
        while (expect_q.size() != 0 && wait_cycles < DRAIN_LIMIT)
        begin
            @(posedge CLK);
            wait_cycles++;
        end
        if (expect_q.size() != 0)
        begin
            $display("Timed out with %0d instructions not retired", expect_q.size());
            other_errors++;
        end
        @(negedge CLK);
        check_word("final retired", legal_count, retired);
        $display("Value errors %0d, other errors %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+rtl
rtl/core_pkg.sv
rtl/pipe_if.sv
rtl/register_file.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/writeback_stage.sv
rtl/rv_core.sv
test/rv_core_sva.sv
test/rv_core_tb.sv
